/* hdl/regPairPkg.sv */
package regPairPkg;

  // Three address bits select one of the eight register pairs
  localparam int pairAddrW = 3;

  // Width of a full pair and of each of its two bytes
  localparam int dataW = 16;
  localparam int byteW = 8;

  // Operations that the execution unit understands
  typedef enum logic [2:0] {
    LDW,
    LDH,
    LDL,
    ADDW,
    INCW,
    DECW,
    SWAP,
    RDW
  } opcodeE;

  // A register pair seen either as one 16-bit word or as its two bytes
  // Word view serves the arithmetic, byte view serves the byte loads and SWAP
  typedef union packed {
    logic [dataW-1:0] word;
    struct packed {
      logic [byteW-1:0] hi;
      logic [byteW-1:0] lo;
    } bytes;
  } regPairU;

endpackage

/* hdl/cmdIf.sv */
`timescale 1ns/1ps

interface cmdIf;

  import regPairPkg::*;

  // Head entry of the command queue
  logic valid;
  opcodeE op;
  logic [pairAddrW-1:0] dst;
  logic [pairAddrW-1:0] srcB;
  logic [pairAddrW-1:0] srcC;
  regPairU imm;

  // Removes the head entry at the clock edge where it is high
  logic pop;

  modport queue (output valid, op, dst, srcB, srcC, imm, input pop);

  modport exec (input valid, op, dst, srcB, srcC, imm, output pop);

endinterface

/* hdl/regFileIf.sv */
`timescale 1ns/1ps

interface regFileIf;

  import regPairPkg::*;

  // Port A also carries the write address
  logic [pairAddrW-1:0] addrA;
  logic [pairAddrW-1:0] addrB;
  logic [pairAddrW-1:0] addrC;

  // Byte-split write port
  regPairU wrData;
  logic weH;
  logic weL;

  // Combinational read data of the current contents
  regPairU rdA;
  regPairU rdB;
  regPairU rdC;

  modport exec (output addrA, addrB, addrC, wrData, weH, weL, input rdA, rdB, rdC);

  modport regs (input addrA, addrB, addrC, wrData, weH, weL, output rdA, rdB, rdC);

endinterface

/* hdl/pairRegFile.sv */
`timescale 1ns/1ps

module pairRegFile (
  input logic clk,
  input logic rstN,
  regFileIf.regs rf
);

  import regPairPkg::*;

  localparam int numPairs = 2 ** pairAddrW;

  // High and low halves are kept in separate banks so each byte
  // can be written on its own
  logic [byteW-1:0] regsH [numPairs];
  logic [byteW-1:0] regsL [numPairs];

  // High bank, written under weH
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < numPairs; i++) begin
        regsH[i] <= '0;
      end
    end else if (rf.weH) begin
      regsH[rf.addrA] <= rf.wrData.bytes.hi;
    end
  end

  // Low bank, written under weL
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < numPairs; i++) begin
        regsL[i] <= '0;
      end
    end else if (rf.weL) begin
      regsL[rf.addrA] <= rf.wrData.bytes.lo;
    end
  end

  // Reads are combinational, so a write shows up on the next cycle's reads
  assign rf.rdA.word = {regsH[rf.addrA], regsL[rf.addrA]};
  assign rf.rdB.word = {regsH[rf.addrB], regsL[rf.addrB]};
  assign rf.rdC.word = {regsH[rf.addrC], regsL[rf.addrC]};

endmodule

/* hdl/cmdCreditQueue.sv */
`timescale 1ns/1ps

module cmdCreditQueue #(
  parameter int cmdDepth = 4
) (
  input logic clk,
  input logic rstN,
  input logic cmdValid,
  input regPairPkg::opcodeE cmdOp,
  input logic [regPairPkg::pairAddrW-1:0] cmdDst,
  input logic [regPairPkg::pairAddrW-1:0] cmdSrcB,
  input logic [regPairPkg::pairAddrW-1:0] cmdSrcC,
  input logic [regPairPkg::dataW-1:0] cmdImm,
  cmdIf.queue q
);

  import regPairPkg::*;

  // Pointer and count widths, kept at least one bit for a depth of one
  localparam int ptrW = (cmdDepth > 1) ? $clog2(cmdDepth) : 1;
  localparam int cntW = $clog2(cmdDepth + 1);

  // Command fields stored side by side, one slot per host credit
  opcodeE opMem [cmdDepth];
  logic [pairAddrW-1:0] dstMem [cmdDepth];
  logic [pairAddrW-1:0] srcBMem [cmdDepth];
  logic [pairAddrW-1:0] srcCMem [cmdDepth];
  logic [dataW-1:0] immMem [cmdDepth];

  logic [ptrW-1:0] wrPtr;
  logic [ptrW-1:0] rdPtr;
  logic [cntW-1:0] count;

  // The host only sends while it holds a credit, so a push never finds the queue full
  always_ff @(posedge clk) begin
    if (cmdValid) begin
      opMem[wrPtr] <= cmdOp;
      dstMem[wrPtr] <= cmdDst;
      srcBMem[wrPtr] <= cmdSrcB;
      srcCMem[wrPtr] <= cmdSrcC;
      immMem[wrPtr] <= cmdImm;
    end
  end

  // Pointers wrap at cmdDepth, which need not be a power of two
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (cmdValid) begin
        wrPtr <= (wrPtr == ptrW'(cmdDepth - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (q.pop) begin
        rdPtr <= (rdPtr == ptrW'(cmdDepth - 1)) ? '0 : rdPtr + 1'b1;
      end
      // Occupancy holds when a push and a pop meet in the same cycle
      case ({cmdValid, q.pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Head entry, visible the cycle after it was stored
  assign q.valid = (count != '0);
  assign q.op = opMem[rdPtr];
  assign q.dst = dstMem[rdPtr];
  assign q.srcB = srcBMem[rdPtr];
  assign q.srcC = srcCMem[rdPtr];
  assign q.imm.word = immMem[rdPtr];

endmodule

/* hdl/pairExecUnit.sv */
`timescale 1ns/1ps

module pairExecUnit #(
  parameter int rspCredits = 2
) (
  input logic clk,
  input logic rstN,
  cmdIf.exec c,
  regFileIf.exec rf,
  input logic rspCreditIn,
  output logic rspValid,
  output logic [regPairPkg::dataW-1:0] rspData,
  output logic rspZero,
  output logic rspCarry,
  output logic cmdCredit
);

  import regPairPkg::*;

  localparam int creditW = $clog2(rspCredits + 1);

  // Response credits currently held by the unit
  logic [creditW-1:0] creditCnt;
  logic pop;

  // Shared adder for ADDW and INCW, one bit wider for the carry
  logic [dataW-1:0] addend;
  logic [dataW:0] sum;

  regPairU result;
  logic carry;
  logic wantH;
  logic wantL;

  // Registered issue flag, drives both the response strobe and the command credit
  logic issued;

  // A command leaves the queue only while a response slot is guaranteed
  assign pop = c.valid && (creditCnt != '0);
  assign c.pop = pop;

  // Destination shares the write port, sources use ports B and C
  assign rf.addrA = c.dst;
  assign rf.addrB = c.srcB;
  assign rf.addrC = c.srcC;

  assign addend = (c.op == ADDW) ? rf.rdC.word : dataW'(1);
  assign sum = {1'b0, rf.rdB.word} + {1'b0, addend};

  always_comb begin
    result = rf.rdB;
    carry = 1'b0;
    wantH = 1'b0;
    wantL = 1'b0;
    case (c.op)
      LDW: begin
        result.word = c.imm.word;
        wantH = 1'b1;
        wantL = 1'b1;
      end
      // Byte loads keep the untouched byte of the destination for the response
      LDH: begin
        result.bytes.hi = c.imm.bytes.lo;
        result.bytes.lo = rf.rdA.bytes.lo;
        wantH = 1'b1;
      end
      LDL: begin
        result.bytes.hi = rf.rdA.bytes.hi;
        result.bytes.lo = c.imm.bytes.lo;
        wantL = 1'b1;
      end
      ADDW, INCW: begin
        result.word = sum[dataW-1:0];
        carry = sum[dataW];
        wantH = 1'b1;
        wantL = 1'b1;
      end
      // Borrow happens only when the source is already zero
      DECW: begin
        result.word = rf.rdB.word - 1'b1;
        carry = (rf.rdB.word == '0);
        wantH = 1'b1;
        wantL = 1'b1;
      end
      SWAP: begin
        result.bytes.hi = rf.rdB.bytes.lo;
        result.bytes.lo = rf.rdB.bytes.hi;
        wantH = 1'b1;
        wantL = 1'b1;
      end
      // Read only, no byte is written
      RDW: result = rf.rdB;
    endcase
  end

  // Write back at the end of the issue cycle
  assign rf.wrData = result;
  assign rf.weH = pop && wantH;
  assign rf.weL = pop && wantL;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      creditCnt <= creditW'(rspCredits);
      issued <= 1'b0;
    end else begin
      // A returned credit and an issue in the same cycle cancel out
      creditCnt <= creditCnt + creditW'(rspCreditIn) - creditW'(pop);
      issued <= pop;
    end
  end

  // Response payload, qualified by rspValid
  always_ff @(posedge clk) begin
    if (pop) begin
      rspData <= result.word;
      rspZero <= (result.word == '0);
      rspCarry <= carry;
    end
  end

  // The freed queue slot is returned to the host with the response
  assign rspValid = issued;
  assign cmdCredit = issued;

endmodule

/* hdl/regPairUnit.sv */
`timescale 1ns/1ps

module regPairUnit #(
  parameter int cmdDepth = 4,
  parameter int rspCredits = 2
) (
  input logic clk,
  input logic rstN,
  input logic cmdValid,
  input regPairPkg::opcodeE cmdOp,
  input logic [regPairPkg::pairAddrW-1:0] cmdDst,
  input logic [regPairPkg::pairAddrW-1:0] cmdSrcB,
  input logic [regPairPkg::pairAddrW-1:0] cmdSrcC,
  input logic [regPairPkg::dataW-1:0] cmdImm,
  output logic cmdCredit,
  output logic rspValid,
  output logic [regPairPkg::dataW-1:0] rspData,
  output logic rspZero,
  output logic rspCarry,
  input logic rspCreditIn
);

  // Queue head towards the execution unit
  cmdIf cmdBus ();

  // Address, data and enables between the execution unit and the registers
  regFileIf rfBus ();

  // Depth matches the command credits the host starts with
  cmdCreditQueue #(
    .cmdDepth(cmdDepth)
  ) cmdQueue (
    .clk(clk),
    .rstN(rstN),
    .cmdValid(cmdValid),
    .cmdOp(cmdOp),
    .cmdDst(cmdDst),
    .cmdSrcB(cmdSrcB),
    .cmdSrcC(cmdSrcC),
    .cmdImm(cmdImm),
    .q(cmdBus.queue)
  );

  pairExecUnit #(
    .rspCredits(rspCredits)
  ) exec (
    .clk(clk),
    .rstN(rstN),
    .c(cmdBus.exec),
    .rf(rfBus.exec),
    .rspCreditIn(rspCreditIn),
    .rspValid(rspValid),
    .rspData(rspData),
    .rspZero(rspZero),
    .rspCarry(rspCarry),
    .cmdCredit(cmdCredit)
  );

  // Register file beside the unit that addresses and writes it
  pairRegFile regs (
    .clk(clk),
    .rstN(rstN),
    .rf(rfBus.regs)
  );

endmodule

/* bench/clkGen.sv */
`timescale 1ns/1ps

module clkGen #(
  parameter int periodNs = 20
) (
  output logic clk
);

  // Free-running clock, low for the first half period
  initial clk = 1'b0;

  always #(periodNs / 2) clk = ~clk;

endmodule

/* bench/regPairUnitAsserts.sv */
`timescale 1ns/1ps

module regPairUnitAsserts (
  input logic clk,
  input logic rstN,
  input logic cmdValid,
  input logic cmdCredit,
  input logic rspValid,
  input logic pop,
  input logic weH,
  input logic weL,
  input logic creditZero
);

  // Running totals of commands taken in and command credits handed back
  int cmdsSent;
  int creditsBack;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      cmdsSent <= 0;
      creditsBack <= 0;
    end else begin
      cmdsSent <= cmdsSent + int'(cmdValid);
      creditsBack <= creditsBack + int'(cmdCredit);
    end
  end

  // A credit can only come back for a command stored in an earlier cycle
  creditsNotAhead: assert property (@(posedge clk) disable iff (!rstN)
    creditsBack + int'(cmdCredit) <= cmdsSent)
    else $error("command credit returned without a matching command");

  // Each response traces back to an issue made while a credit was held
  rspNeedsCredit: assert property (@(posedge clk) disable iff (!rstN)
    rspValid |-> $past(!creditZero))
    else $error("response sent although the credit count was zero");

  noWriteWithoutPop: assert property (@(posedge clk) disable iff (!rstN)
    !pop |-> (!weH && !weL))
    else $error("register file written without an issued command");

endmodule

bind regPairUnit regPairUnitAsserts chk (
  .clk(clk),
  .rstN(rstN),
  .cmdValid(cmdValid),
  .cmdCredit(cmdCredit),
  .rspValid(rspValid),
  .pop(cmdBus.pop),
  .weH(rfBus.weH),
  .weL(rfBus.weL),
  .creditZero(exec.creditCnt == '0)
);

/* bench/regPairUnitTb.sv */
`timescale 1ns/1ps

module regPairUnitTb;

  import regPairPkg::*;

  // Same values as the DUT defaults
  localparam int cmdDepth = 4;
  localparam int rspCredits = 2;
  localparam int waitLimit = 200;

  logic clk;
  logic rstN;
  logic cmdValid;
  opcodeE cmdOp;
  logic [pairAddrW-1:0] cmdDst;
  logic [pairAddrW-1:0] cmdSrcB;
  logic [pairAddrW-1:0] cmdSrcC;
  logic [dataW-1:0] cmdImm;
  logic cmdCredit;
  logic rspValid;
  logic [dataW-1:0] rspData;
  logic rspZero;
  logic rspCarry;
  logic rspCreditIn;

  integer seed;

  // Host side of both credit loops
  int hostCredits;
  int owedCredits;
  bit holdCredits;

  // Reference pairs and the predicted responses, packed as {zero, carry, data}
  logic [dataW-1:0] model [2**pairAddrW];
  logic [dataW+1:0] expQ [$];

  string testName;
  int errors;
  int testStartErrors;
  int testsRun;
  int rspCount;

  clkGen #(.periodNs(20)) clock (.clk(clk));

  regPairUnit dut (
    .clk(clk),
    .rstN(rstN),
    .cmdValid(cmdValid),
    .cmdOp(cmdOp),
    .cmdDst(cmdDst),
    .cmdSrcB(cmdSrcB),
    .cmdSrcC(cmdSrcC),
    .cmdImm(cmdImm),
    .cmdCredit(cmdCredit),
    .rspValid(rspValid),
    .rspData(rspData),
    .rspZero(rspZero),
    .rspCarry(rspCarry),
    .rspCreditIn(rspCreditIn)
  );

  // Applies one command to the reference pairs, following the result table
  function automatic void predict(input opcodeE op, input logic [2:0] d, input logic [2:0] b,
                                  input logic [2:0] c, input logic [15:0] imm);
    logic [16:0] s;
    logic [15:0] v;
    logic cy;
    cy = 1'b0;
    case (op)
      LDW: v = imm;
      LDH: v = {imm[7:0], model[d][7:0]};
      LDL: v = {model[d][15:8], imm[7:0]};
      ADDW, INCW: begin
        s = {1'b0, model[b]} + ((op == ADDW) ? {1'b0, model[c]} : 17'd1);
        v = s[15:0];
        cy = s[16];
      end
      DECW: begin
        v = model[b] - 16'd1;
        cy = (model[b] == 16'd0);
      end
      SWAP: v = {model[b][7:0], model[b][15:8]};
      default: v = model[b];
    endcase
    if (op != RDW) model[d] = v;
    expQ.push_back({v == 16'd0, cy, v});
  endfunction

  // One falling edge: check the response, collect credits, drop last cycle's pulses
  task automatic step();
    logic [dataW+1:0] exp;
    @(negedge clk);
    cmdValid = 1'b0;
    rspCreditIn = 1'b0;
    if (cmdCredit) hostCredits++;
    if (rspValid) begin
      rspCount++;
      owedCredits++;
      assert (expQ.size() != 0) else begin
        $display("%s: a response arrived with no command outstanding", testName);
        errors++;
      end
      if (expQ.size() != 0) begin
        exp = expQ.pop_front();
        assert ({rspZero, rspCarry, rspData} == exp) else begin
          $display("[FAIL] %s: expected data %h zero %b carry %b, actual data %h zero %b carry %b",
                   testName, exp[15:0], exp[17], exp[16], rspData, rspZero, rspCarry);
          errors++;
        end
      end
    end
    // Consumed responses are handed back at random gaps
    if (owedCredits > 0 && !holdCredits && ($random(seed) & 1) != 0) begin
      rspCreditIn = 1'b1;
      owedCredits--;
    end
  endtask

  task automatic issue(input opcodeE op, input logic [2:0] d, input logic [2:0] b,
                       input logic [2:0] c, input logic [15:0] imm);
    cmdValid = 1'b1;
    cmdOp = op;
    cmdDst = d;
    cmdSrcB = b;
    cmdSrcC = c;
    cmdImm = imm;
    hostCredits--;
    predict(op, d, b, c, imm);
  endtask

  task automatic issueRandom();
    issue(opcodeE'(3'($random(seed))), 3'($random(seed)), 3'($random(seed)),
          3'($random(seed)), 16'($random(seed)));
  endtask

  task automatic waitCredit();
    int waited;
    waited = 0;
    step();
    while (hostCredits == 0 && waited < waitLimit) begin
      step();
      waited++;
    end
    assert (hostCredits > 0) else begin
      $display("%s: timed out waiting for a command credit", testName);
      errors++;
    end
  endtask

  task automatic send(input opcodeE op, input logic [2:0] d, input logic [2:0] b,
                      input logic [2:0] c, input logic [15:0] imm);
    waitCredit();
    issue(op, d, b, c, imm);
  endtask

  // Waits until every response is in and every credit of both loops is back
  task automatic drain();
    int waited;
    waited = 0;
    while ((expQ.size() != 0 || hostCredits != cmdDepth || owedCredits != 0) &&
           waited < 4 * waitLimit) begin
      step();
      waited++;
    end
    assert (expQ.size() == 0 && hostCredits == cmdDepth) else begin
      $display("%s: timed out with %0d responses missing and %0d command credits held back",
               testName, expQ.size(), cmdDepth - hostCredits);
      errors++;
    end
  endtask

  task automatic beginTest(input string name);
    testName = name;
    testStartErrors = errors;
  endtask

  task automatic endTest();
    testsRun++;
    $display("%s %s", testName, (errors == testStartErrors) ? "passed" : "failed");
  endtask

  initial begin
    logic [2:0] d;
    logic [2:0] b;
    logic [2:0] c;
    opcodeE arith;
    opcodeE chain [4];
    int sentHere;
    int seenBefore;
    chain = '{INCW, ADDW, SWAP, DECW};
    seed = 86488;
    errors = 0;
    testsRun = 0;
    rspCount = 0;
    hostCredits = cmdDepth;
    owedCredits = 0;
    holdCredits = 1'b0;
    rstN = 1'b0;
    cmdValid = 1'b0;
    cmdOp = LDW;
    cmdDst = '0;
    cmdSrcB = '0;
    cmdSrcC = '0;
    cmdImm = '0;
    rspCreditIn = 1'b0;
    for (int i = 0; i < 2**pairAddrW; i++) model[i] = '0;
    repeat (4) @(negedge clk);
    rstN = 1'b1;

    // Idle cycles first, step flags any response that shows up unasked
    beginTest("resetState");
    repeat (5) step();
    for (int i = 0; i < 2**pairAddrW; i++) send(RDW, 3'(i), 3'(i), 3'(i), '0);
    drain();
    endTest();

    // Each byte load keeps the other byte, then SWAP exchanges them
    beginTest("byteWrites");
    for (int i = 0; i < 4; i++) begin
      d = 3'($random(seed));
      send(LDW, d, d, d, 16'($random(seed)));
      send(LDH, d, d, d, 16'($random(seed)));
      send(LDL, d, d, d, 16'($random(seed)));
      send(SWAP, d, d, d, '0);
    end
    drain();
    endTest();

    beginTest("wordArith");
    for (int i = 0; i < 24; i++) begin
      b = 3'($random(seed));
      c = 3'($random(seed));
      d = 3'($random(seed));
      arith = (i % 3 == 0) ? ADDW : ((i % 3 == 1) ? INCW : DECW);
      send(LDW, b, b, b, 16'($random(seed)));
      send(LDW, c, c, c, 16'($random(seed)));
      send(arith, d, b, c, '0);
    end
    // Wrap cases, FFFF+1 and FFFF+FFFF carry, 0-1 borrows
    send(LDW, 3'd1, 3'd1, 3'd1, 16'hFFFF);
    send(INCW, 3'd2, 3'd1, 3'd1, '0);
    send(ADDW, 3'd3, 3'd1, 3'd1, '0);
    send(LDW, 3'd4, 3'd4, 3'd4, 16'h0000);
    send(DECW, 3'd5, 3'd4, 3'd4, '0);
    drain();
    endTest();

    // Every command reads the pair the previous one just wrote
    beginTest("dependent");
    send(LDW, 3'd6, 3'd6, 3'd6, 16'($random(seed)));
    for (int i = 0; i < 12; i++) send(chain[i % 4], 3'd6, 3'd6, 3'd6, '0);
    drain();
    endTest();

    // No response credits go back, so only rspCredits responses may appear
    beginTest("backPressure");
    holdCredits = 1'b1;
    sentHere = 0;
    seenBefore = rspCount;
    repeat (30) begin
      step();
      if (hostCredits > 0) begin
        issueRandom();
        sentHere++;
      end
      assert (sentHere - (rspCount - seenBefore) <= cmdDepth) else begin
        $display("%s: more than %0d commands outstanding", testName, cmdDepth);
        errors++;
      end
    end
    assert (rspCount - seenBefore == rspCredits) else begin
      $display("[FAIL] %s: expected %0d responses, actual %0d", testName, rspCredits,
               rspCount - seenBefore);
      errors++;
    end
    holdCredits = 1'b0;
    drain();
    endTest();

    beginTest("randomSoak");
    repeat (300) begin
      waitCredit();
      issueRandom();
    end
    drain();
    endTest();

    $display("Tests run: %0d, responses checked: %0d, errors: %0d", testsRun, rspCount, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* list.f */
hdl/regPairPkg.sv
hdl/cmdIf.sv
hdl/regFileIf.sv
hdl/pairRegFile.sv
hdl/cmdCreditQueue.sv
hdl/pairExecUnit.sv
hdl/regPairUnit.sv
bench/clkGen.sv
bench/regPairUnitAsserts.sv
bench/regPairUnitTb.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the result line

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module regPairUnitTb -f list.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/VregPairUnitTb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qxF "TEST RESULT: PASS"; then
  exit 0
fi
exit 1
